//--- flist.f
logic/surf_link_pkg.sv
logic/surf_link_tracker.sv
logic/surf_live_detector.sv
logic/surf_autostartup.sv
logic/surf_link_top.sv
verif/surf_link_tb.sv

//--- verif/surf_link_tb.sv
`timescale 1ns/100ps
// drives seven SURF links through boot, training, alignment, live and loss
module surf_link_tb import surf_link_pkg::*; ();

    localparam dout_byte_t DOUT_TRAIN  = 8'h6A;
    localparam int         LOSS_CYCLES = 16;
    // the whole run needs a few hundred system cycles, so this leaves a wide margin
    localparam int         MAX_CYCLES  = 4000;
    // wishbone cycles to wait before a compare, enough for both clock crossings
    localparam int         SETTLE_WB   = 10;

    // expected state of one tracker
    typedef struct packed {
        logic       boot;
        logic [7:0] cnt;
        logic       trainin;
        logic       trainout;
        logic       live;
        logic       mis;
    } link_model_t;

    logic                       sys_clk;
    logic                       wb_clk;
    logic                       sys_clk_ok;
    logic [COUT_W*NUM_SURF-1:0] cout_bus;
    logic [DOUT_W*NUM_SURF-1:0] dout_bus;
    logic                       autotrain_en;
    logic                       align_ack;
    surf_mask_t                 trainin_req;
    surf_mask_t                 trainout_rdy;
    surf_mask_t                 surf_live;
    surf_mask_t                 surf_misaligned;
    surf_mask_t                 train_complete;
    surf_mask_t                 cin_train;
    logic                       align_req;
    surf_idx_t                  align_idx;

    link_model_t mst [NUM_SURF];
    surf_mask_t  tc_model;
    surf_mask_t  aligned_mask;
    surf_mask_t  aligned_seen;
    surf_mask_t  exp_trainin;
    surf_mask_t  exp_trainout;
    surf_mask_t  exp_live;
    surf_mask_t  exp_mis;
    surf_mask_t  exp_tc;
    surf_idx_t   served_q [$];
    surf_idx_t   exp_order [6] = '{3'd2, 3'd3, 3'd0, 3'd1, 3'd4, 3'd5};
    surf_idx_t   ack_idx;
    surf_idx_t   held_idx;
    logic        req_seen;
    logic        check_pending;
    string       check_tag;
    int          n_checks;
    int          n_errors;
    int          cycle_cnt;

    surf_link_top #(
        .DOUT_TRAIN         (DOUT_TRAIN),
        .COUT_LOSS_CYCLES   (LOSS_CYCLES)
    ) dut0 (
        .sys_clk_i          (sys_clk),
        .sys_clk_ok_i       (sys_clk_ok),
        .wb_clk_i           (wb_clk),
        .cout_i             (cout_bus),
        .dout_i             (dout_bus),
        .cin_autotrain_en_i (autotrain_en),
        .align_ack_i        (align_ack),
        .trainin_req_o      (trainin_req),
        .trainout_rdy_o     (trainout_rdy),
        .surf_live_o        (surf_live),
        .surf_misaligned_o  (surf_misaligned),
        .train_complete_o   (train_complete),
        .cin_train_o        (cin_train),
        .align_req_o        (align_req),
        .align_idx_o        (align_idx)
    );

    // 4 ns system clock and 6 ns wishbone clock, so their edges drift against each other
    always #2 sys_clk = ~sys_clk;
    always #3 wb_clk = ~wb_clk;

    // one step of the link rules, all flags move on the edge after their condition
    function automatic link_model_t ref_step(input link_model_t s, input cout_nib_t c,
                                             input dout_byte_t d, input logic tc);
        link_model_t n;
        logic        idle;
        logic        lost;
        logic        leave;
        idle  = (c == 4'hF);
        lost  = (s.cnt == 8'(LOSS_CYCLES));
        leave = tc && (d != DOUT_TRAIN);
        n = s;
        // idle COUT is only counted while live or before the first boot
        n.cnt      = ((s.live || !s.boot) && idle) ? (lost ? 8'd1 : s.cnt + 8'd1) : 8'd0;
        n.boot     = s.boot | lost;
        n.trainin  = lost ? 1'b0 : (s.trainin | ((d == 8'h00) && s.boot));
        n.trainout = lost ? 1'b0 : (s.trainout | (s.trainin && !idle));
        n.live     = lost ? 1'b0 : (s.live | leave);
        // a nonzero exit from the pattern marks the capture as off for good
        n.mis      = s.mis | (leave && (d != 8'h00));
        return n;
    endfunction

    // model runs on the same edges as the trackers and sees the inputs they see
    always @(posedge sys_clk) begin
        if (!sys_clk_ok) begin
            for (int i = 0; i < NUM_SURF; i++) begin
                mst[i] = '0;
            end
            tc_model     = '0;
            aligned_seen = '0;
        end else begin
            for (int i = 0; i < NUM_SURF; i++) begin
                mst[i] = ref_step(mst[i], cout_bus[COUT_W*i +: COUT_W],
                                  dout_bus[DOUT_W*i +: DOUT_W], tc_model[i]);
            end
            // a finished exchange marks the link, losing train-out unmarks it
            tc_model = tc_model | (aligned_mask & ~aligned_seen);
            aligned_seen = aligned_mask;
            for (int i = 0; i < NUM_SURF; i++) begin
                tc_model[i] = tc_model[i] & mst[i].trainout;
            end
        end
        for (int i = 0; i < NUM_SURF; i++) begin
            exp_trainin[i]  <= mst[i].trainin;
            exp_trainout[i] <= mst[i].trainout;
            exp_live[i]     <= mst[i].live;
            exp_mis[i]      <= mst[i].mis;
        end
        exp_tc <= tc_model;
    end

    // aligner stand-in, locks after a random number of wishbone cycles
    initial begin
        void'($urandom(32'h7b2b2128));
        forever begin
            @(posedge wb_clk);
            if (align_req && !align_ack) begin
                // the link this exchange should serve, in lowest-index-first order
                ack_idx = exp_order[served_q.size()];
                served_q.push_back(align_idx);
                repeat ($urandom_range(1, 5)) @(posedge wb_clk);
                align_ack <= 1'b1;
                @(posedge wb_clk);
                while (align_req) begin
                    @(posedge wb_clk);
                end
                repeat ($urandom_range(1, 5)) @(posedge wb_clk);
                align_ack <= 1'b0;
                aligned_mask[ack_idx] <= 1'b1;
            end
        end
    end

    // index must hold for as long as req stays up
    always @(posedge wb_clk) begin
        if (sys_clk_ok && align_req && req_seen) begin
            assert (align_idx == held_idx) else begin
                n_errors++;
                $display("ERROR at %0t ns: align_idx_o moved from %0d to %0d with req high",
                         $time, held_idx, align_idx);
            end
        end
        req_seen <= align_req;
        held_idx <= align_idx;
    end

    task automatic compare_mask(input string what, input surf_mask_t got, input surf_mask_t exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("ERROR at %0t ns: %s, %s is %b, expected %b",
                     $time, check_tag, what, got, exp);
        end
    endtask

    // compares everything once the crossings have settled
    always begin
        wait (check_pending);
        repeat (SETTLE_WB) @(posedge wb_clk);
        compare_mask("trainin_req_o", trainin_req, exp_trainin);
        compare_mask("trainout_rdy_o", trainout_rdy, exp_trainout);
        compare_mask("surf_live_o", surf_live, exp_live);
        compare_mask("surf_misaligned_o", surf_misaligned, exp_mis);
        compare_mask("train_complete_o", train_complete, exp_tc);
        compare_mask("cin_train_o", cin_train, exp_trainin & {NUM_SURF{autotrain_en}});
        // between exchanges the request has to be down
        compare_mask("align_req_o", surf_mask_t'(align_req), '0);
        check_pending = 1'b0;
    end

    task automatic run_check(input string tag);
        check_tag = tag;
        check_pending = 1'b1;
        wait (!check_pending);
    endtask

    // call right after a rising edge of the system clock
    task automatic drive_link(input int idx, input cout_nib_t c, input dout_byte_t d);
        cout_bus[COUT_W*idx +: COUT_W] <= c;
        dout_bus[DOUT_W*idx +: DOUT_W] <= d;
    endtask

    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d system cycles", MAX_CYCLES);
            $display("checks: %0d, errors: %0d", n_checks, n_errors);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        sys_clk       = 1'b0;
        wb_clk        = 1'b0;
        sys_clk_ok    = 1'b0;
        cout_bus      = '0;
        dout_bus      = '0;
        autotrain_en  = 1'b0;
        align_ack     = 1'b0;
        aligned_mask  = '0;
        req_seen      = 1'b0;
        held_idx      = '0;
        check_pending = 1'b0;
        n_checks      = 0;
        n_errors      = 0;
        cycle_cnt     = 0;
        repeat (5) @(posedge sys_clk);
        sys_clk_ok <= 1'b1;
        run_check("after reset");
        // COUT stays non-idle, so DOUT zero comes before any boot
        repeat (20) @(posedge sys_clk);
        run_check("dout zero before boot");
        // SURFs 0 to 5 boot, SURF 6 never does
        @(posedge sys_clk);
        for (int i = 0; i < 6; i++) begin
            drive_link(i, 4'hF, 8'h00);
        end
        repeat (LOSS_CYCLES + 4) @(posedge sys_clk);
        run_check("boot with autotrain off");
        @(posedge sys_clk);
        autotrain_en <= 1'b1;
        run_check("autotrain on");
        // SURF 2 trains out, gets aligned and goes live through a clean zero
        @(posedge sys_clk);
        drive_link(2, 4'h5, DOUT_TRAIN);
        wait (train_complete[2]);
        run_check("surf 2 aligned");
        @(posedge sys_clk);
        drive_link(2, 4'h5, 8'h00);
        run_check("surf 2 live");
        // SURF 3 leaves the pattern for 8'h60, the flag has to stick
        @(posedge sys_clk);
        drive_link(3, 4'h9, DOUT_TRAIN);
        wait (train_complete[3]);
        run_check("surf 3 aligned");
        @(posedge sys_clk);
        drive_link(3, 4'h9, 8'h60);
        run_check("surf 3 misaligned");
        @(posedge sys_clk);
        drive_link(3, 4'h9, 8'h00);
        run_check("surf 3 stays misaligned");
        // one idle cycle short of the loss count
        @(posedge sys_clk);
        drive_link(2, 4'hF, 8'h00);
        repeat (LOSS_CYCLES - 1) @(posedge sys_clk);
        drive_link(2, 4'h5, 8'h00);
        run_check("surf 2 short idle run");
        // the full run drops the link, DOUT back on the pattern
        @(posedge sys_clk);
        drive_link(2, 4'hF, DOUT_TRAIN);
        repeat (LOSS_CYCLES + 4) @(posedge sys_clk);
        run_check("surf 2 lost");
        // four links ready on the same edge
        @(posedge sys_clk);
        drive_link(0, 4'h3, DOUT_TRAIN);
        drive_link(1, 4'h3, DOUT_TRAIN);
        drive_link(4, 4'h3, DOUT_TRAIN);
        drive_link(5, 4'h3, DOUT_TRAIN);
        wait ((train_complete & 7'b0110011) == 7'b0110011);
        run_check("four links aligned");
        @(posedge sys_clk);
        drive_link(0, 4'h3, 8'h00);
        drive_link(1, 4'h3, 8'h00);
        drive_link(4, 4'h3, 8'h00);
        drive_link(5, 4'h3, 8'h00);
        run_check("four links live");
        // each ready link served once, lowest index first
        n_checks++;
        assert (served_q.size() == 6) else begin
            n_errors++;
            $display("ERROR at %0t ns: aligner served %0d requests, expected 6",
                     $time, served_q.size());
        end
        foreach (served_q[k]) begin
            if (k < 6) begin
                n_checks++;
                assert (served_q[k] == exp_order[k]) else begin
                    n_errors++;
                    $display("ERROR at %0t ns: request %0d went to SURF %0d, expected %0d",
                             $time, k, served_q[k], exp_order[k]);
                end
            end
        end
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- logic/surf_link_top.sv
`timescale 1ns/100ps
// link bring-up for the seven SURFs of the trigger board
// the detector watches COUT and DOUT, the sequencer runs alignment in the wishbone clock
module surf_link_top import surf_link_pkg::*; #(
    parameter dout_byte_t  DOUT_TRAIN       = 8'h6A,
    parameter int unsigned COUT_LOSS_CYCLES = 16
) (
    input  logic                       sys_clk_i,
    input  logic                       sys_clk_ok_i,
    input  logic                       wb_clk_i,
    input  logic [COUT_W*NUM_SURF-1:0] cout_i,
    input  logic [DOUT_W*NUM_SURF-1:0] dout_i,
    input  logic                       cin_autotrain_en_i,
    input  logic                       align_ack_i,
    output surf_mask_t                 trainin_req_o,
    output surf_mask_t                 trainout_rdy_o,
    output surf_mask_t                 surf_live_o,
    output surf_mask_t                 surf_misaligned_o,
    output surf_mask_t                 train_complete_o,
    output surf_mask_t                 cin_train_o,
    output logic                       align_req_o,
    output surf_idx_t                  align_idx_o
);

    // wishbone-side status and the complete marks looping back to the detector
    surf_mask_t trainin_req;
    surf_mask_t trainout_rdy;
    surf_mask_t train_complete;

    surf_live_detector #(
        .DOUT_TRAIN        (DOUT_TRAIN),
        .COUT_LOSS_CYCLES  (COUT_LOSS_CYCLES)
    ) u_detector (
        .sys_clk_i         (sys_clk_i),
        .sys_clk_ok_i      (sys_clk_ok_i),
        .wb_clk_i          (wb_clk_i),
        .cout_i            (cout_i),
        .dout_i            (dout_i),
        .train_complete_i  (train_complete),
        .trainin_req_o     (trainin_req),
        .trainout_rdy_o    (trainout_rdy),
        .surf_live_o       (surf_live_o),
        .surf_misaligned_o (surf_misaligned_o)
    );

    surf_autostartup u_startup (
        .wb_clk_i           (wb_clk_i),
        .sys_clk_ok_i       (sys_clk_ok_i),
        .trainin_req_i      (trainin_req),
        .trainout_rdy_i     (trainout_rdy),
        .cin_autotrain_en_i (cin_autotrain_en_i),
        .align_ack_i        (align_ack_i),
        .train_complete_o   (train_complete),
        .cin_train_o        (cin_train_o),
        .align_req_o        (align_req_o),
        .align_idx_o        (align_idx_o)
    );

    assign trainin_req_o    = trainin_req;
    assign trainout_rdy_o   = trainout_rdy;
    assign train_complete_o = train_complete;

endmodule

//--- logic/surf_autostartup.sv
`timescale 1ns/100ps
// brings each SURF output up without register writes
// a link that reports train-out ready gets aligned by the external aligner, one at a time
// the sequencer then raises that link's train-complete so the tracker can go live
module surf_autostartup import surf_link_pkg::*; (
    input  logic           wb_clk_i,
    input  logic           sys_clk_ok_i,
    input  surf_mask_t     trainin_req_i,
    input  surf_mask_t     trainout_rdy_i,
    // lets train-in requests switch CIN into training on their own
    input  logic           cin_autotrain_en_i,
    input  logic           align_ack_i,
    output surf_mask_t     train_complete_o,
    output surf_mask_t     cin_train_o,
    output logic           align_req_o,
    output surf_idx_t      align_idx_o
);

    startup_state_t state;
    surf_mask_t     pending;
    surf_mask_t     done_mask;
    surf_idx_t      pick_idx;
    logic           pick_valid;

    // links ready for alignment that have not been marked complete yet
    assign pending = trainout_rdy_i & ~train_complete_o;

    // lowest pending index wins, so walk down from the top and keep overwriting
    always_comb begin
        pick_idx   = '0;
        pick_valid = 1'b0;
        for (int i = NUM_SURF - 1; i >= 0; i--) begin
            if (pending[i]) begin
                pick_idx   = surf_idx_t'(i);
                pick_valid = 1'b1;
            end
        end
    end

    // the one bit to set as the handshake finishes
    always_comb begin
        done_mask = '0;
        if (state == ST_DONE) begin
            done_mask[align_idx_o] = 1'b1;
        end
    end

    // four-phase exchange, the aligner may hold ack for as long as it needs
    always_ff @(posedge wb_clk_i or negedge sys_clk_ok_i) begin
        if (!sys_clk_ok_i) begin
            state       <= ST_SCAN;
            align_req_o <= 1'b0;
            align_idx_o <= '0;
        end else begin
            case (state)
                ST_SCAN: begin
                    // index only moves here, where req and ack are both low
                    if (pick_valid && !align_ack_i) begin
                        align_idx_o <= pick_idx;
                        align_req_o <= 1'b1;
                        state       <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    // aligner has locked on this link
                    if (align_ack_i) begin
                        align_req_o <= 1'b0;
                        state       <= ST_REL;
                    end
                end
                ST_REL: begin
                    if (!align_ack_i) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    state <= ST_SCAN;
                end
                default: begin
                    align_req_o <= 1'b0;
                    state       <= ST_SCAN;
                end
            endcase
        end
    end

    // the mark stays only while the link still reports train-out ready
    // a link that dropped out during its exchange is not marked at all
    always_ff @(posedge wb_clk_i or negedge sys_clk_ok_i) begin
        if (!sys_clk_ok_i) begin
            train_complete_o <= '0;
        end else begin
            train_complete_o <= (train_complete_o | done_mask) & trainout_rdy_i;
        end
    end

    // CIN training just follows the request when autotraining is on
    assign cin_train_o = trainin_req_i & {NUM_SURF{cin_autotrain_en_i}};

    // the aligner is working on align_idx_o for as long as req is up
    a_idx_stable: assert property (
        @(posedge wb_clk_i) disable iff (!sys_clk_ok_i)
        align_req_o |=> (!align_req_o || $stable(align_idx_o))
    );

    // a new request must never start on top of an ack left over from the last one
    a_req_after_ack_low: assert property (
        @(posedge wb_clk_i) disable iff (!sys_clk_ok_i)
        $rose(align_req_o) |-> !align_ack_i
    );

endmodule

//--- logic/surf_live_detector.sv
`timescale 1ns/100ps
// tracks the link state of every SURF from COUT and DOUT in the system clock
// the status masks are handed over to the wishbone clock for the sequencer and registers
module surf_live_detector import surf_link_pkg::*; #(
    parameter dout_byte_t  DOUT_TRAIN       = 8'h6A,
    parameter int unsigned COUT_LOSS_CYCLES = 16
) (
    input  logic                       sys_clk_i,
    input  logic                       sys_clk_ok_i,
    input  logic                       wb_clk_i,
    // all seven COUT nibbles, SURF 0 in the low bits
    input  logic [COUT_W*NUM_SURF-1:0] cout_i,
    // all seven DOUT bytes, SURF 0 in the low bits
    input  logic [DOUT_W*NUM_SURF-1:0] dout_i,
    // train-complete mask from the sequencer in the wishbone clock
    input  surf_mask_t                 train_complete_i,
    output surf_mask_t                 trainin_req_o,
    output surf_mask_t                 trainout_rdy_o,
    output surf_mask_t                 surf_live_o,
    output surf_mask_t                 surf_misaligned_o
);

    // four status masks cross together, each sitting in its own slice
    localparam int STAT_W = 4 * NUM_SURF;

    surf_mask_t        tc_meta;
    surf_mask_t        tc_sync;
    surf_mask_t        trainin_sys;
    surf_mask_t        trainout_sys;
    surf_mask_t        live_sys;
    surf_mask_t        misaligned_sys;
    logic [STAT_W-1:0] status_sys;
    logic [STAT_W-1:0] status_meta;
    logic [STAT_W-1:0] status_wb;

    // train-complete comes from the wishbone side, two flops bring it into the system clock
    always_ff @(posedge sys_clk_i or negedge sys_clk_ok_i) begin
        if (!sys_clk_ok_i) begin
            tc_meta <= '0;
            tc_sync <= '0;
        end else begin
            tc_meta <= train_complete_i;
            tc_sync <= tc_meta;
        end
    end

    // one tracker per SURF on its own slice of the buses
    for (genvar i = 0; i < NUM_SURF; i++) begin : g_link
        surf_link_tracker #(
            .DOUT_TRAIN       (DOUT_TRAIN),
            .COUT_LOSS_CYCLES (COUT_LOSS_CYCLES)
        ) u_tracker (
            .sys_clk_i        (sys_clk_i),
            .sys_clk_ok_i     (sys_clk_ok_i),
            .cout_i           (cout_i[COUT_W*i +: COUT_W]),
            .dout_i           (dout_i[DOUT_W*i +: DOUT_W]),
            .train_complete_i (tc_sync[i]),
            .trainin_req_o    (trainin_sys[i]),
            .trainout_rdy_o   (trainout_sys[i]),
            .live_o           (live_sys[i]),
            .misaligned_o     (misaligned_sys[i])
        );
    end

    // each bit is a slow level, so a plain two-flop chain per bit is enough
    // the masks may land a cycle apart from each other, nothing downstream relies on that
    assign status_sys = {misaligned_sys, live_sys, trainout_sys, trainin_sys};

    always_ff @(posedge wb_clk_i or negedge sys_clk_ok_i) begin
        if (!sys_clk_ok_i) begin
            status_meta <= '0;
            status_wb   <= '0;
        end else begin
            status_meta <= status_sys;
            status_wb   <= status_meta;
        end
    end

    assign trainin_req_o     = status_wb[0          +: NUM_SURF];
    assign trainout_rdy_o    = status_wb[NUM_SURF   +: NUM_SURF];
    assign surf_live_o       = status_wb[2*NUM_SURF +: NUM_SURF];
    assign surf_misaligned_o = status_wb[3*NUM_SURF +: NUM_SURF];

endmodule

//--- logic/surf_link_tracker.sv
`timescale 1ns/100ps
// follows one SURF through boot, train-in, train-out and live
// everything here runs on the system clock, the same domain as COUT and DOUT
module surf_link_tracker import surf_link_pkg::*; #(
    parameter dout_byte_t  DOUT_TRAIN       = 8'h6A,
    parameter int unsigned COUT_LOSS_CYCLES = 16
) (
    input  logic       sys_clk_i,
    input  logic       sys_clk_ok_i,
    input  cout_nib_t  cout_i,
    input  dout_byte_t dout_i,
    // train-complete from the sequencer, already in the system clock domain
    input  logic       train_complete_i,
    output logic       trainin_req_o,
    output logic       trainout_rdy_o,
    output logic       live_o,
    output logic       misaligned_o
);

    // one extra bit above the count, it is the loss strobe
    localparam int CNT_W = $clog2(COUT_LOSS_CYCLES) + 1;

    // the loss count has to be a power of two so the top bit marks the end of the run
    if ((COUT_LOSS_CYCLES < 4) || (COUT_LOSS_CYCLES > 64) ||
        ((COUT_LOSS_CYCLES & (COUT_LOSS_CYCLES - 1)) != 0)) begin : g_bad_loss_cycles
        $error("COUT_LOSS_CYCLES must be a power of two from 4 to 64");
    end

    logic             boot_seen;
    logic [CNT_W-1:0] loss_cnt;
    logic             cout_lost;
    logic             cout_idle;
    logic             dout_zero;
    logic             dout_out_of_train;

    // an idle SURF drives COUT high on all four lines
    assign cout_idle = (cout_i == {COUT_W{1'b1}});
    assign dout_zero = (dout_i == '0);

    // DOUT has left the training pattern after the aligner finished
    assign dout_out_of_train = train_complete_i && (dout_i != DOUT_TRAIN);

    // top bit of the counter goes high after COUT_LOSS_CYCLES idle cycles in a row
    assign cout_lost = loss_cnt[CNT_W-1];

    // the loss counter only runs while the link is live or before the first boot
    // any non-idle COUT restarts the run from zero
    always_ff @(posedge sys_clk_i or negedge sys_clk_ok_i) begin
        if (!sys_clk_ok_i) begin
            loss_cnt <= '0;
        end else if ((live_o || !boot_seen) && cout_idle) begin
            // the strobe bit is dropped so it only lasts a single cycle
            loss_cnt <= {1'b0, loss_cnt[CNT_W-2:0]} + 1'b1;
        end else begin
            loss_cnt <= '0;
        end
    end

    // we start far ahead of the SURFs, so a long idle COUT run is how a boot shows up
    // once seen it stays set until the next reset
    always_ff @(posedge sys_clk_i or negedge sys_clk_ok_i) begin
        if (!sys_clk_ok_i) begin
            boot_seen <= 1'b0;
        end else if (cout_lost) begin
            boot_seen <= 1'b1;
        end
    end

    // DOUT zero after boot means the SURF has clocks and wants CIN trained
    always_ff @(posedge sys_clk_i or negedge sys_clk_ok_i) begin
        if (!sys_clk_ok_i) begin
            trainin_req_o <= 1'b0;
        end else if (cout_lost) begin
            trainin_req_o <= 1'b0;
        end else if (dout_zero && boot_seen) begin
            trainin_req_o <= 1'b1;
        end
    end

    // COUT dropping out of idle during train-in means the SURF outputs are in training
    always_ff @(posedge sys_clk_i or negedge sys_clk_ok_i) begin
        if (!sys_clk_ok_i) begin
            trainout_rdy_o <= 1'b0;
        end else if (cout_lost) begin
            trainout_rdy_o <= 1'b0;
        end else if (trainin_req_o && !cout_idle) begin
            trainout_rdy_o <= 1'b1;
        end
    end

    // the link goes live once DOUT leaves the pattern after alignment
    // live together with a clear misaligned flag is what lets DOUT be used
    always_ff @(posedge sys_clk_i or negedge sys_clk_ok_i) begin
        if (!sys_clk_ok_i) begin
            live_o <= 1'b0;
        end else if (cout_lost) begin
            live_o <= 1'b0;
        end else if (dout_out_of_train) begin
            live_o <= 1'b1;
        end
    end

    // a clean exit goes pattern then zero, anything else means the capture is off
    // this one is sticky, only reset clears it
    always_ff @(posedge sys_clk_i or negedge sys_clk_ok_i) begin
        if (!sys_clk_ok_i) begin
            misaligned_o <= 1'b0;
        end else if (dout_out_of_train && !dout_zero) begin
            misaligned_o <= 1'b1;
        end
    end

    // live can only come up on a cycle where the sequencer had already finished alignment
    a_live_needs_complete: assert property (
        @(posedge sys_clk_i) disable iff (!sys_clk_ok_i)
        $rose(live_o) |-> $past(train_complete_i)
    );

endmodule

//--- logic/surf_link_pkg.sv
package surf_link_pkg;

    // the trigger board serves this many SURF digitizers
    localparam int NUM_SURF = 7;

    // width of one COUT nibble and one DOUT byte per SURF
    localparam int COUT_W = 4;
    localparam int DOUT_W = 8;

    // COUT is a nibble per SURF, and an idle COUT is all ones
    typedef logic [COUT_W-1:0] cout_nib_t;

    // DOUT is a byte per SURF, and zero from a booted SURF asks for train-in
    typedef logic [DOUT_W-1:0] dout_byte_t;

    // one bit per SURF, shared by every status and control vector
    typedef logic [NUM_SURF-1:0] surf_mask_t;

    // index of one SURF, wide enough for NUM_SURF links
    typedef logic [2:0] surf_idx_t;

    // states of the wishbone-side alignment sequencer
    typedef enum logic [1:0] {
        // look for a ready link that has not been aligned yet
        ST_SCAN = 2'd0,
        // request is up, wait for the aligner to raise ack
        ST_REQ  = 2'd1,
        // request is down, wait for the aligner to drop ack
        ST_REL  = 2'd2,
        // mark the link complete and go back to scanning
        ST_DONE = 2'd3
    } startup_state_t;

endpackage
